//--- src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define DATA_W      32  // datapath width
`define RF_ADDR_W   5
`define OPCODE_W    5
`define ALU_OP_W    11  // one-hot alu control
`define DRAM_AW     8   // 256 words of data ram
`define MUL_CYCLES  4   // ex cycles spent on a mul

// bit positions inside the one-hot alu control
`define ALU_ADD     0
`define ALU_SUB     1
`define ALU_AND     2
`define ALU_OR      3
`define ALU_XOR     4
`define ALU_SLL     5
`define ALU_SRL     6
`define ALU_SRA     7
`define ALU_SLT     8
`define ALU_SLTU    9
`define ALU_MUL     10

`endif

//--- src/isa_pkg.sv
`include "cpu_consts.svh"

package isa_pkg;

    typedef logic [`DATA_W-1:0]    word_t;
    typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

    // numbering is what the instruction records carry
    typedef enum logic [`OPCODE_W-1:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_MUL,
        OP_LD_B,
        OP_LD_H,
        OP_LD_W,
        OP_LD_BU,
        OP_LD_HU,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W
    } opcode_e;

    typedef enum logic [1:0] {
        MW_BYTE,
        MW_HALF,
        MW_WORD
    } mem_width_e;

endpackage

//--- src/pipe_pkg.sv
`include "cpu_consts.svh"

package pipe_pkg;

    typedef logic [`ALU_OP_W-1:0] alu_op_t;   // one-hot
    typedef logic [3:0]           byte_en_t;  // one bit per byte lane
    typedef logic [`DRAM_AW-1:0]  sram_addr_t; // word address

    // iterative multiplier sequencing
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

endpackage

//--- src/id_stage.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module id_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 in_valid,
    input  isa_pkg::opcode_e     in_op,
    input  isa_pkg::word_t       in_src1,
    input  isa_pkg::word_t       in_src2,
    input  isa_pkg::word_t       in_st_data,
    input  isa_pkg::rf_addr_t    in_rd,
    input  isa_pkg::word_t       in_pc,
    output logic                 in_allowin,
    input  logic                 ex_allowin,
    output logic                 id_to_ex_valid,
    output pipe_pkg::alu_op_t    id_alu_op,
    output isa_pkg::word_t       id_src1,
    output isa_pkg::word_t       id_src2,
    output isa_pkg::word_t       id_st_data,
    output logic                 id_mem_rd,
    output logic                 id_mem_wr,
    output isa_pkg::mem_width_e  id_mem_width,
    output logic                 id_ld_unsigned,
    output logic                 id_rf_we,
    output isa_pkg::rf_addr_t    id_rd,
    output isa_pkg::word_t       id_pc
);

    logic             id_valid;
    isa_pkg::opcode_e id_op;

    // decode is combinational, so id is always ready to go
    assign in_allowin     = ~id_valid | ex_allowin;
    assign id_to_ex_valid = id_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (in_allowin) begin
            id_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            id_op      <= in_op;
            id_src1    <= in_src1;
            id_src2    <= in_src2;
            id_st_data <= in_st_data;
            id_rd      <= in_rd;
            id_pc      <= in_pc;
        end
    end

    always_comb begin
        id_alu_op    = '0;
        id_mem_rd    = 1'b0;
        id_mem_wr    = 1'b0;
        id_mem_width = isa_pkg::MW_WORD;
        case (id_op)
            isa_pkg::OP_ADD:  id_alu_op[`ALU_ADD]  = 1'b1;
            isa_pkg::OP_SUB:  id_alu_op[`ALU_SUB]  = 1'b1;
            isa_pkg::OP_AND:  id_alu_op[`ALU_AND]  = 1'b1;
            isa_pkg::OP_OR:   id_alu_op[`ALU_OR]   = 1'b1;
            isa_pkg::OP_XOR:  id_alu_op[`ALU_XOR]  = 1'b1;
            isa_pkg::OP_SLL:  id_alu_op[`ALU_SLL]  = 1'b1;
            isa_pkg::OP_SRL:  id_alu_op[`ALU_SRL]  = 1'b1;
            isa_pkg::OP_SRA:  id_alu_op[`ALU_SRA]  = 1'b1;
            isa_pkg::OP_SLT:  id_alu_op[`ALU_SLT]  = 1'b1;
            isa_pkg::OP_SLTU: id_alu_op[`ALU_SLTU] = 1'b1;
            isa_pkg::OP_MUL:  id_alu_op[`ALU_MUL]  = 1'b1;
            isa_pkg::OP_LD_B, isa_pkg::OP_LD_BU: begin
                id_mem_rd    = 1'b1;
                id_mem_width = isa_pkg::MW_BYTE;
            end
            isa_pkg::OP_LD_H, isa_pkg::OP_LD_HU: begin
                id_mem_rd    = 1'b1;
                id_mem_width = isa_pkg::MW_HALF;
            end
            isa_pkg::OP_LD_W: id_mem_rd = 1'b1;
            isa_pkg::OP_ST_B: begin
                id_mem_wr    = 1'b1;
                id_mem_width = isa_pkg::MW_BYTE;
            end
            isa_pkg::OP_ST_H: begin
                id_mem_wr    = 1'b1;
                id_mem_width = isa_pkg::MW_HALF;
            end
            isa_pkg::OP_ST_W: id_mem_wr = 1'b1;
            default: ;
        endcase
        if (id_mem_rd || id_mem_wr) begin
            id_alu_op[`ALU_ADD] = 1'b1; // address = src1 + src2
        end
    end

    assign id_ld_unsigned = (id_op == isa_pkg::OP_LD_BU) || (id_op == isa_pkg::OP_LD_HU);
    assign id_rf_we       = ~id_mem_wr; // stores write no register

endmodule

//--- src/alu.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module alu (
    input  logic              clk,
    input  logic              resetn,
    input  pipe_pkg::alu_op_t alu_op,
    input  isa_pkg::word_t    alu_src1,
    input  isa_pkg::word_t    alu_src2,
    input  logic              alu_start,
    output isa_pkg::word_t    alu_result,
    output logic              complete
);

    localparam int MUL_CHUNK = `DATA_W / `MUL_CYCLES; // multiplier bits per step
    localparam int CNT_W     = $clog2(`MUL_CYCLES);

    pipe_pkg::mul_state_e mul_state;
    logic [CNT_W-1:0]     mul_cnt;
    isa_pkg::word_t       mul_acc;
    isa_pkg::word_t       mul_digit;
    isa_pkg::word_t       mul_sum;
    logic                 mul_step;
    logic [4:0]           shamt;

    assign shamt = alu_src2[4:0];

    // one chunk of src2 per cycle, the last one is added combinationally in DONE
    assign mul_digit = isa_pkg::word_t'(alu_src2[mul_cnt*MUL_CHUNK +: MUL_CHUNK]);
    assign mul_sum   = ((mul_state == pipe_pkg::MUL_IDLE) ? '0 : mul_acc)
                     + ((alu_src1 * mul_digit) << (mul_cnt * MUL_CHUNK));
    assign mul_step  = (mul_state == pipe_pkg::MUL_BUSY)
                     || (mul_state == pipe_pkg::MUL_IDLE && alu_start && alu_op[`ALU_MUL]);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mul_state <= pipe_pkg::MUL_IDLE;
            mul_cnt   <= '0;
        end else begin
            case (mul_state)
                pipe_pkg::MUL_IDLE: begin
                    if (alu_start && alu_op[`ALU_MUL]) begin
                        mul_state <= pipe_pkg::MUL_BUSY;
                        mul_cnt   <= mul_cnt + 1'b1;
                    end
                end
                pipe_pkg::MUL_BUSY: begin
                    mul_cnt <= mul_cnt + 1'b1;
                    if (mul_cnt == CNT_W'(`MUL_CYCLES - 2)) begin
                        mul_state <= pipe_pkg::MUL_DONE;
                    end
                end
                pipe_pkg::MUL_DONE: begin
                    if (!alu_start) begin // result taken by ex
                        mul_state <= pipe_pkg::MUL_IDLE;
                        mul_cnt   <= '0;
                    end
                end
                default: mul_state <= pipe_pkg::MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mul_step) begin
            mul_acc <= mul_sum; // partial product
        end
    end

    assign alu_result =
          ({`DATA_W{alu_op[`ALU_ADD]}}  & (alu_src1 + alu_src2))
        | ({`DATA_W{alu_op[`ALU_SUB]}}  & (alu_src1 - alu_src2))
        | ({`DATA_W{alu_op[`ALU_AND]}}  & (alu_src1 & alu_src2))
        | ({`DATA_W{alu_op[`ALU_OR]}}   & (alu_src1 | alu_src2))
        | ({`DATA_W{alu_op[`ALU_XOR]}}  & (alu_src1 ^ alu_src2))
        | ({`DATA_W{alu_op[`ALU_SLL]}}  & (alu_src1 << shamt))
        | ({`DATA_W{alu_op[`ALU_SRL]}}  & (alu_src1 >> shamt))
        | ({`DATA_W{alu_op[`ALU_SRA]}}  & isa_pkg::word_t'($signed(alu_src1) >>> shamt))
        | ({`DATA_W{alu_op[`ALU_SLT]}}  & isa_pkg::word_t'($signed(alu_src1) < $signed(alu_src2)))
        | ({`DATA_W{alu_op[`ALU_SLTU]}} & isa_pkg::word_t'(alu_src1 < alu_src2))
        | ({`DATA_W{alu_op[`ALU_MUL]}}  & mul_sum);

    assign complete = ~alu_op[`ALU_MUL] | (mul_state == pipe_pkg::MUL_DONE);

    // a mul that starts must finish within its latency
    a_mul_latency: assert property (@(posedge clk) disable iff (!resetn)
        (mul_state == pipe_pkg::MUL_IDLE && alu_start && alu_op[`ALU_MUL])
        |-> ##[1:`MUL_CYCLES-1] complete);

endmodule

//--- src/ex_stage.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module ex_stage (
    input  logic                  clk,
    input  logic                  resetn,
    output logic                  ex_allowin,
    input  logic                  id_to_ex_valid,
    input  pipe_pkg::alu_op_t     id_alu_op,
    input  isa_pkg::word_t        id_src1,
    input  isa_pkg::word_t        id_src2,
    input  isa_pkg::word_t        id_st_data,
    input  logic                  id_mem_rd,
    input  logic                  id_mem_wr,
    input  isa_pkg::mem_width_e   id_mem_width,
    input  logic                  id_ld_unsigned,
    input  logic                  id_rf_we,
    input  isa_pkg::rf_addr_t     id_rd,
    input  isa_pkg::word_t        id_pc,
    input  logic                  mem_allowin,
    output logic                  ex_to_mem_valid,
    output isa_pkg::word_t        ex_pc,
    output logic                  ex_rf_we,
    output isa_pkg::rf_addr_t     ex_rd,
    output isa_pkg::word_t        ex_alu_result,
    output logic                  ex_mem_rd,
    output isa_pkg::mem_width_e   ex_mem_width,
    output logic                  ex_ld_unsigned,
    output logic                  data_sram_en,
    output pipe_pkg::byte_en_t    data_sram_we,
    output pipe_pkg::sram_addr_t  data_sram_addr,
    output isa_pkg::word_t        data_sram_wdata
);

    logic               ex_valid;
    logic               ex_ready_go;
    logic               ex_fire;
    pipe_pkg::alu_op_t  ex_alu_op;
    isa_pkg::word_t     ex_src1;
    isa_pkg::word_t     ex_src2;
    isa_pkg::word_t     ex_st_data;
    logic               ex_mem_wr;
    pipe_pkg::byte_en_t st_be;

    assign ex_allowin      = ~ex_valid | (ex_ready_go & mem_allowin);
    assign ex_to_mem_valid = ex_valid & ex_ready_go;
    assign ex_fire         = ex_to_mem_valid & mem_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= id_to_ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_ex_valid && ex_allowin) begin
            ex_alu_op      <= id_alu_op;
            ex_src1        <= id_src1;
            ex_src2        <= id_src2;
            ex_st_data     <= id_st_data;
            ex_mem_rd      <= id_mem_rd;
            ex_mem_wr      <= id_mem_wr;
            ex_mem_width   <= id_mem_width;
            ex_ld_unsigned <= id_ld_unsigned;
            ex_rf_we       <= id_rf_we;
            ex_rd          <= id_rd;
            ex_pc          <= id_pc;
        end
    end

    alu u_alu (
        .clk        (clk),
        .resetn     (resetn),
        .alu_op     (ex_alu_op),
        .alu_src1   (ex_src1),
        .alu_src2   (ex_src2),
        .alu_start  (ex_valid & ~ex_fire), // low once the result leaves
        .alu_result (ex_alu_result),
        .complete   (ex_ready_go)
    );

    // store lanes from width and address bits 1:0
    always_comb begin
        case (ex_mem_width)
            isa_pkg::MW_BYTE: begin
                data_sram_wdata = {4{ex_st_data[7:0]}};
                st_be           = pipe_pkg::byte_en_t'(4'b0001 << ex_alu_result[1:0]);
            end
            isa_pkg::MW_HALF: begin
                data_sram_wdata = {2{ex_st_data[15:0]}};
                st_be           = ex_alu_result[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                data_sram_wdata = ex_st_data;
                st_be           = 4'b1111;
            end
        endcase
    end

    // request only on the transfer, so a stall never repeats it
    assign data_sram_en   = ex_fire & (ex_mem_rd | ex_mem_wr);
    assign data_sram_we   = {4{ex_fire & ex_mem_wr}} & st_be;
    assign data_sram_addr = ex_alu_result[`DRAM_AW+1:2];

    // a store transfer always writes the lane its address points at
    a_we_on_store: assert property (@(posedge clk) disable iff (!resetn)
        (ex_fire && ex_mem_wr) |-> data_sram_we[ex_alu_result[1:0]]);

    // an offered result waits unchanged until mem takes it
    a_out_valid: assert property (@(posedge clk) disable iff (!resetn)
        (ex_to_mem_valid && !mem_allowin)
        |=> (ex_to_mem_valid && $stable(ex_alu_result)));

endmodule

//--- src/mem_stage.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module mem_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 ex_to_mem_valid,
    input  isa_pkg::word_t       ex_pc,
    input  logic                 ex_rf_we,
    input  isa_pkg::rf_addr_t    ex_rd,
    input  isa_pkg::word_t       ex_alu_result,
    input  logic                 ex_mem_rd,
    input  isa_pkg::mem_width_e  ex_mem_width,
    input  logic                 ex_ld_unsigned,
    output logic                 mem_allowin,
    input  isa_pkg::word_t       data_sram_rdata,
    input  logic                 out_allowin,
    output logic                 wb_valid,
    output isa_pkg::word_t       wb_pc,
    output logic                 wb_rf_we,
    output isa_pkg::rf_addr_t    wb_rd,
    output isa_pkg::word_t       wb_rf_wdata
);

    logic                mem_valid;
    isa_pkg::word_t      mem_alu_result;
    logic                mem_ld;
    isa_pkg::mem_width_e mem_width;
    logic                mem_unsigned;
    logic [7:0]          ld_byte;
    logic [15:0]         ld_half;
    isa_pkg::word_t      ld_data;

    assign mem_allowin = ~mem_valid | out_allowin;
    assign wb_valid    = mem_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            wb_pc          <= ex_pc;
            wb_rf_we       <= ex_rf_we;
            wb_rd          <= ex_rd;
            mem_alu_result <= ex_alu_result;
            mem_ld         <= ex_mem_rd;
            mem_width      <= ex_mem_width;
            mem_unsigned   <= ex_ld_unsigned;
        end
    end

    // ram output holds until the next request, which only comes with the next transfer in
    assign ld_byte = data_sram_rdata[{mem_alu_result[1:0], 3'b000} +: 8];
    assign ld_half = data_sram_rdata[{mem_alu_result[1], 4'b0000} +: 16];

    always_comb begin
        case (mem_width)
            isa_pkg::MW_BYTE: ld_data = {{24{~mem_unsigned & ld_byte[7]}}, ld_byte};
            isa_pkg::MW_HALF: ld_data = {{16{~mem_unsigned & ld_half[15]}}, ld_half};
            default:          ld_data = data_sram_rdata;
        endcase
    end

    assign wb_rf_wdata = mem_ld ? ld_data : mem_alu_result;

    a_wb_hold: assert property (@(posedge clk) disable iff (!resetn)
        (wb_valid && !out_allowin) |=> (wb_valid && $stable(wb_rf_wdata)));

endmodule

//--- src/data_sram.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module data_sram (
    input  logic                 clk,
    input  logic                 en,
    input  pipe_pkg::byte_en_t   we,
    input  pipe_pkg::sram_addr_t addr,
    input  isa_pkg::word_t       wdata,
    output isa_pkg::word_t       rdata
);

    isa_pkg::word_t mem [0:(1<<`DRAM_AW)-1];

    initial begin
        for (int i = 0; i < (1 << `DRAM_AW); i++) begin
            mem[i] = '0; // ram starts cleared
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr]; // old data on a write
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- src/exe_mem_top.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module exe_mem_top (
    input  logic              clk,
    input  logic              resetn,
    input  logic              in_valid,
    input  isa_pkg::opcode_e  in_op,
    input  isa_pkg::word_t    in_src1,
    input  isa_pkg::word_t    in_src2,
    input  isa_pkg::word_t    in_st_data,
    input  isa_pkg::rf_addr_t in_rd,
    input  isa_pkg::word_t    in_pc,
    output logic              in_allowin,
    input  logic              out_allowin,
    output logic              wb_valid,
    output isa_pkg::word_t    wb_pc,
    output logic              wb_rf_we,
    output isa_pkg::rf_addr_t wb_rd,
    output isa_pkg::word_t    wb_rf_wdata
);

    logic                 ex_allowin;
    logic                 id_to_ex_valid;
    pipe_pkg::alu_op_t    id_alu_op;
    isa_pkg::word_t       id_src1;
    isa_pkg::word_t       id_src2;
    isa_pkg::word_t       id_st_data;
    logic                 id_mem_rd;
    logic                 id_mem_wr;
    isa_pkg::mem_width_e  id_mem_width;
    logic                 id_ld_unsigned;
    logic                 id_rf_we;
    isa_pkg::rf_addr_t    id_rd;
    isa_pkg::word_t       id_pc;

    logic                 mem_allowin;
    logic                 ex_to_mem_valid;
    isa_pkg::word_t       ex_pc;
    logic                 ex_rf_we;
    isa_pkg::rf_addr_t    ex_rd;
    isa_pkg::word_t       ex_alu_result;
    logic                 ex_mem_rd;
    isa_pkg::mem_width_e  ex_mem_width;
    logic                 ex_ld_unsigned;

    logic                 data_sram_en;
    pipe_pkg::byte_en_t   data_sram_we;
    pipe_pkg::sram_addr_t data_sram_addr;
    isa_pkg::word_t       data_sram_wdata;
    isa_pkg::word_t       data_sram_rdata;

    id_stage u_id_stage (
        .clk            (clk),
        .resetn         (resetn),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_src1        (in_src1),
        .in_src2        (in_src2),
        .in_st_data     (in_st_data),
        .in_rd          (in_rd),
        .in_pc          (in_pc),
        .in_allowin     (in_allowin),
        .ex_allowin     (ex_allowin),
        .id_to_ex_valid (id_to_ex_valid),
        .id_alu_op      (id_alu_op),
        .id_src1        (id_src1),
        .id_src2        (id_src2),
        .id_st_data     (id_st_data),
        .id_mem_rd      (id_mem_rd),
        .id_mem_wr      (id_mem_wr),
        .id_mem_width   (id_mem_width),
        .id_ld_unsigned (id_ld_unsigned),
        .id_rf_we       (id_rf_we),
        .id_rd          (id_rd),
        .id_pc          (id_pc)
    );

    ex_stage u_ex_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ex_allowin      (ex_allowin),
        .id_to_ex_valid  (id_to_ex_valid),
        .id_alu_op       (id_alu_op),
        .id_src1         (id_src1),
        .id_src2         (id_src2),
        .id_st_data      (id_st_data),
        .id_mem_rd       (id_mem_rd),
        .id_mem_wr       (id_mem_wr),
        .id_mem_width    (id_mem_width),
        .id_ld_unsigned  (id_ld_unsigned),
        .id_rf_we        (id_rf_we),
        .id_rd           (id_rd),
        .id_pc           (id_pc),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_pc           (ex_pc),
        .ex_rf_we        (ex_rf_we),
        .ex_rd           (ex_rd),
        .ex_alu_result   (ex_alu_result),
        .ex_mem_rd       (ex_mem_rd),
        .ex_mem_width    (ex_mem_width),
        .ex_ld_unsigned  (ex_ld_unsigned),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_pc           (ex_pc),
        .ex_rf_we        (ex_rf_we),
        .ex_rd           (ex_rd),
        .ex_alu_result   (ex_alu_result),
        .ex_mem_rd       (ex_mem_rd),
        .ex_mem_width    (ex_mem_width),
        .ex_ld_unsigned  (ex_ld_unsigned),
        .mem_allowin     (mem_allowin),
        .data_sram_rdata (data_sram_rdata),
        .out_allowin     (out_allowin),
        .wb_valid        (wb_valid),
        .wb_pc           (wb_pc),
        .wb_rf_we        (wb_rf_we),
        .wb_rd           (wb_rd),
        .wb_rf_wdata     (wb_rf_wdata)
    );

    data_sram u_data_sram (
        .clk   (clk),
        .en    (data_sram_en),
        .we    (data_sram_we),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (data_sram_rdata)
    );

endmodule

//--- verification/tb_exe_mem.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module tb_exe_mem;

    logic              clk;
    logic              resetn;
    logic              in_valid;
    isa_pkg::opcode_e  in_op;
    isa_pkg::word_t    in_src1;
    isa_pkg::word_t    in_src2;
    isa_pkg::word_t    in_st_data;
    isa_pkg::rf_addr_t in_rd;
    isa_pkg::word_t    in_pc;
    logic              in_allowin;
    logic              out_allowin;
    logic              wb_valid;
    isa_pkg::word_t    wb_pc;
    logic              wb_rf_we;
    isa_pkg::rf_addr_t wb_rd;
    isa_pkg::word_t    wb_rf_wdata;

    logic [4:0]        rec_op[$];
    isa_pkg::word_t    rec_src1[$];
    isa_pkg::word_t    rec_src2[$];
    isa_pkg::word_t    rec_st[$];
    isa_pkg::rf_addr_t rec_rd[$];
    isa_pkg::word_t    rec_pc[$];
    logic              rec_we[$];
    isa_pkg::word_t    rec_wdata[$];
    int                pending[$];  // record indices accepted, oldest first

    int     value_errors = 0;
    int     other_errors = 0;
    int     retired = 0;
    int     limit = 0;
    int     cycles = 0;
    integer seed = 32'h56b9;

    exe_mem_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic read_stimulus();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f_op, f_src1, f_src2, f_st;
        logic [31:0] f_rd, f_pc, f_we, f_wdata;
        fd = $fopen("verification/exe_mem_stimulus.txt", "r");
        assert (fd != 0) else begin
            $display("the stimulus file could not be opened");
            other_errors++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.getc(0) != "#") begin  // skip the column notes
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                   f_op, f_src1, f_src2, f_st, f_rd, f_pc, f_we, f_wdata);
                    if (code == 8) begin
                        rec_op.push_back(f_op[4:0]);
                        rec_src1.push_back(f_src1);
                        rec_src2.push_back(f_src2);
                        rec_st.push_back(f_st);
                        rec_rd.push_back(isa_pkg::rf_addr_t'(f_rd));
                        rec_pc.push_back(f_pc);
                        rec_we.push_back(f_we[0]);
                        rec_wdata.push_back(f_wdata);
                    end
                end
            end
            $fclose(fd);
        end
        assert (rec_op.size() > 0) else begin
            $display("no instruction records were read");
            other_errors++;
        end
    endtask

    task automatic drive_record(input int k);
        in_valid   = 1'b1;
        in_op      = isa_pkg::opcode_e'(rec_op[k]);
        in_src1    = rec_src1[k];
        in_src2    = rec_src2[k];
        in_st_data = rec_st[k];
        in_rd      = rec_rd[k];
        in_pc      = rec_pc[k];
    endtask

    task automatic compare_value(input string name, input isa_pkg::word_t got,
                                 input isa_pkg::word_t exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic retire_check();
        int k;
        retired++;
        assert (pending.size() > 0) else begin
            $display("a result retired at %0t ns with no instruction outstanding", $time);
            other_errors++;
        end
        if (pending.size() > 0) begin
            k = pending.pop_front();  // in order, so always the oldest
            compare_value("wb_pc", wb_pc, rec_pc[k]);
            compare_value("wb_rf_we", 32'(wb_rf_we), 32'(rec_we[k]));
            compare_value("wb_rd", 32'(wb_rd), 32'(rec_rd[k]));
            compare_value("wb_rf_wdata", wb_rf_wdata, rec_wdata[k]);
        end
    endtask

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    initial begin : watchdog
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d records retired",
                 cycles, retired, rec_op.size());
        other_errors++;
        finish_run();
    end

    initial begin : stimulus
        int   idx;
        logic fired;
        resetn      = 1'b0;
        in_valid    = 1'b0;
        in_op       = isa_pkg::OP_ADD;
        in_src1     = '0;
        in_src2     = '0;
        in_st_data  = '0;
        in_rd       = '0;
        in_pc       = '0;
        out_allowin = 1'b1;
        idx         = 0;
        fired       = 1'b0;
        read_stimulus();
        limit = rec_op.size() * (`MUL_CYCLES + 3) * 4 + 100;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        #1;
        assert (!wb_valid && in_allowin) else begin
            $display("after reset wb_valid is %b and in_allowin is %b", wb_valid, in_allowin);
            other_errors++;
        end
        while (retired < rec_op.size()) begin
            @(negedge clk);
            if (fired) begin
                in_valid = 1'b0;
                idx++;
            end
            if (!in_valid && idx < rec_op.size()) begin
                drive_record(idx);
            end
            out_allowin = ($random(seed) % 3) != 0;  // low about a third of the time
            #1;  // inputs settle, stable until the next rising edge
            fired = in_valid && in_allowin;
            if (fired) begin
                pending.push_back(idx);
            end
            if (wb_valid && out_allowin) begin
                retire_check();
            end
        end
        repeat (4) begin  // a repeated retirement would show up here
            @(negedge clk);
            out_allowin = 1'b1;
            #1;
            if (wb_valid) begin
                retire_check();
            end
        end
        assert (pending.size() == 0) else begin
            $display("%0d accepted instructions never retired", pending.size());
            other_errors++;
        end
        assert (retired == rec_op.size()) else begin
            $display("%0d results retired for %0d records", retired, rec_op.size());
            other_errors++;
        end
        finish_run();
    end

endmodule

//--- list.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/id_stage.sv
src/alu.sv
src/ex_stage.sv
src/mem_stage.sv
src/data_sram.sv
src/exe_mem_top.sv
verification/tb_exe_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the exe_mem testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_exe_mem \
    -f list.f -o sim_exe_mem \
    && ./obj_dir/sim_exe_mem > sim.log 2>&1 \
    || { echo "simulation build or run did not complete"; exit 1; }

cat sim.log
grep -qx "All checks passed" sim.log \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

//--- verification/exe_mem_stimulus.txt
# columns, all hex: opcode src1 src2 st_data rd pc expected_rf_we expected_wb_data
# opcodes: 00 add .. 09 sltu, 0a mul, 0b ld_b 0c ld_h 0d ld_w 0e ld_bu 0f ld_hu, 10 st_b 11 st_h 12 st_w
00 00000005 00000003 00000000 01 00001000 1 00000008
01 00000003 00000005 00000000 02 00001004 1 fffffffe
02 f0f0f0f0 ff00ff00 00000000 03 00001008 1 f000f000
03 f0f0f0f0 0f0f0000 00000000 04 0000100c 1 fffff0f0
04 aaaa5555 ffff0000 00000000 05 00001010 1 55555555
05 00000001 0000001f 00000000 06 00001014 1 80000000
05 12345678 00000024 00000000 07 00001018 1 23456780
06 80000000 0000001f 00000000 08 0000101c 1 00000001
07 80000000 00000004 00000000 09 00001020 1 f8000000
07 fffffff0 00000002 00000000 0a 00001024 1 fffffffc
08 ffffffff 00000001 00000000 0b 00001028 1 00000001
09 ffffffff 00000001 00000000 0c 0000102c 1 00000000
08 00000001 ffffffff 00000000 0d 00001030 1 00000000
09 00000001 ffffffff 00000000 0e 00001034 1 00000001
0a 00000007 00000006 00000000 0f 00001038 1 0000002a
00 00000010 00000020 00000000 10 0000103c 1 00000030
0a 00012345 00001000 00000000 11 00001040 1 12345000
0a ffffffff 00000003 00000000 12 00001044 1 fffffffd
0a 00010001 00010001 00000000 13 00001048 1 00020001
01 00000000 00000001 00000000 14 0000104c 1 ffffffff
12 00000100 00000000 8badf00d 00 00001050 0 00000100
10 00000200 00000001 000000a5 00 00001054 0 00000201
10 00000200 00000003 00000080 00 00001058 0 00000203
11 00000300 00000002 00001234 00 0000105c 0 00000302
11 00000300 00000000 0000fedc 00 00001060 0 00000300
0d 00000100 00000000 00000000 15 00001064 1 8badf00d
0b 00000200 00000001 00000000 16 00001068 1 ffffffa5
0e 00000200 00000001 00000000 17 0000106c 1 000000a5
0b 00000201 00000002 00000000 18 00001070 1 ffffff80
0e 00000200 00000000 00000000 19 00001074 1 00000000
0c 00000300 00000000 00000000 1a 00001078 1 fffffedc
0f 00000300 00000000 00000000 1b 0000107c 1 0000fedc
0c 00000300 00000002 00000000 1c 00001080 1 00001234
0d 00000200 00000000 00000000 1d 00001084 1 8000a500
0f 00000200 00000002 00000000 1e 00001088 1 00008000
12 00000104 00000000 cafebabe 00 0000108c 0 00000104
0d 00000104 00000000 00000000 1f 00001090 1 cafebabe
0b 00000104 00000000 00000000 01 00001094 1 ffffffbe
